/* csr_index_engine.f */
verilog/csr_engine_pkg.sv
verilog/csr_index_generator.sv
verilog/csr_response_router.sv
verilog/csr_index_lane.sv
verilog/csr_packet_merger.sv
verilog/csr_index_engine.sv
testbench/csr_mem_model.sv
testbench/tb_csr_index_engine.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_index_engine -f csr_index_engine.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

/* testbench/csr_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_mem_model #(
    parameter int SEED = 32'h27e
) (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic [csr_engine_pkg::ADDR_W-1:0]     base_addr,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic [csr_engine_pkg::ADDR_W-1:0]     wb_adr,
    output logic                                  wb_ack,
    output logic [csr_engine_pkg::DATA_W-1:0]     wb_dat
);

    integer seed = SEED;
    logic busy = 1'b0;
    logic [1:0] wait_cnt = 2'd0;
    logic ack_q = 1'b0;
    logic [csr_engine_pkg::DATA_W-1:0] dat_q = '0;
    logic [31:0] rel_adr;
    logic [31:0] vertex;
    logic [31:0] start_off;

    // Byte offset of the access from the table base
    assign rel_adr = wb_adr - base_addr;
    // Vertex of the word being read
    assign vertex = rel_adr >> 3;
    // Index words start at v*16+5 with degree v mod 4
    // Low address bits skew the start so a misaligned read shows up in the data
    assign start_off = vertex * 32'd16 + 32'd5 + {29'd0, rel_adr[2:0]};

    assign wb_ack = ack_q;
    assign wb_dat = dat_q;

    always @(posedge ap_clk) begin
        int delay;
        if (areset_csr_engine) begin
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (wb_cyc && wb_stb && !ack_q) begin
                if (!busy) begin
                    // Fresh strobe is acked after one to three cycles
                    delay = $unsigned($random(seed)) % 3;
                    if (delay == 0) begin
                        ack_q <= 1'b1;
                        dat_q <= {start_off, start_off + (vertex % 32'd4)};
                    end else begin
                        busy     <= 1'b1;
                        wait_cnt <= 2'(delay - 1);
                    end
                end else if (wait_cnt == 2'd0) begin
                    busy  <= 1'b0;
                    ack_q <= 1'b1;
                    dat_q <= {start_off, start_off + (vertex % 32'd4)};
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_csr_index_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_index_engine;

    localparam int RAND_SEED = 32'h27e;
    // 64 cycles per vertex over both runs, plus slack
    localparam int TIMEOUT_CYCLES = 64 * (20 + 13) + 500;

    logic ap_clk = 1'b0;
    logic areset_csr_engine = 1'b1;
    logic start = 1'b0;
    logic [31:0] desc_base_addr = '0;
    logic [31:0] desc_first_vertex = '0;
    logic [31:0] desc_vertex_count = '0;
    logic out_rd_en = 1'b0;
    logic wb_cyc;
    logic wb_stb;
    logic wb_ack;
    logic [csr_engine_pkg::ADDR_W-1:0] wb_adr;
    logic [csr_engine_pkg::DATA_W-1:0] wb_dat;
    logic out_valid;
    logic done;
    logic [csr_engine_pkg::VERTEX_W-1:0] out_vertex;
    logic [csr_engine_pkg::OFFSET_W-1:0] out_offset;
    logic [csr_engine_pkg::OFFSET_W-1:0] out_degree;

    // Scoreboard, written only by the monitor
    logic started = 1'b0;
    logic [31:0] run_base = '0;
    logic [31:0] run_first = '0;
    logic [31:0] run_count = '0;
    logic [31:0] next_vertex = '0;
    logic [63:0] seen = '0;
    int ack_count = 0;
    int rec_count = 0;
    int done_hold = 0;
    int monitor_errors = 0;
    int run_errors = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    integer rd_seed = RAND_SEED;

    always #4 ap_clk = ~ap_clk;

    csr_index_engine dut0 (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine), .start(start),
        .desc_base_addr(desc_base_addr), .desc_first_vertex(desc_first_vertex),
        .desc_vertex_count(desc_vertex_count), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_adr(wb_adr), .wb_ack(wb_ack), .wb_dat(wb_dat), .out_valid(out_valid),
        .out_rd_en(out_rd_en), .out_vertex(out_vertex), .out_offset(out_offset),
        .out_degree(out_degree), .done(done)
    );

    csr_mem_model #(.SEED(RAND_SEED)) mem0 (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .base_addr(desc_base_addr), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_adr(wb_adr), .wb_ack(wb_ack), .wb_dat(wb_dat)
    );

    // Vertices of a range whose degree v mod 4 is nonzero
    function automatic int expected_records(input logic [31:0] first, input logic [31:0] count);
        int n;
        n = 0;
        for (int i = 0; i < int'(count); i++) begin
            if ((first + 32'(i)) % 32'd4 != 32'd0) begin
                n++;
            end
        end
        return n;
    endfunction

    // Output consumer, pops roughly 60 percent of cycles
    always @(posedge ap_clk) begin
        out_rd_en <= ($unsigned($random(rd_seed)) % 32'd10) < 32'd6;
    end

    // ------------------------------------------------------------------------
    // Monitor
    // ------------------------------------------------------------------------
    logic stb_waiting = 1'b0;
    logic out_held = 1'b0;
    logic [31:0] held_adr = '0;
    logic [31:0] held_vertex = '0;
    logic [31:0] held_offset = '0;
    logic [31:0] held_degree = '0;

    always @(posedge ap_clk) begin
        logic [31:0] off;
        if (!areset_csr_engine) begin
            // Quiet until the first descriptor
            if (!started) begin
                assert (!wb_cyc && !wb_stb && !out_valid && !done) else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: bus or output active before first start", $time);
                end
            end
            // New descriptor taken, done from the last run lingers two cycles
            if (start) begin
                started     = 1'b1;
                run_base    = desc_base_addr;
                run_first   = desc_first_vertex;
                run_count   = desc_vertex_count;
                next_vertex = desc_first_vertex;
                ack_count   = 0;
                rec_count   = 0;
                seen        = '0;
                done_hold   = 2;
            end
            if (stb_waiting) begin
                assert (wb_cyc && wb_stb && wb_adr == held_adr) else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: strobe or address %h moved before ack", $time, wb_adr);
                end
            end
            // Reads in ascending order, one per vertex
            if (wb_cyc && wb_stb && wb_ack) begin
                assert (wb_adr == run_base + next_vertex * 32'd8 && ack_count < int'(run_count))
                else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: read at %h, expected %h", $time, wb_adr,
                             run_base + next_vertex * 32'd8);
                end
                next_vertex = next_vertex + 32'd1;
                ack_count++;
            end
            stb_waiting = wb_cyc && wb_stb && !wb_ack;
            held_adr    = wb_adr;
            // Back-pressure keeps the output register still
            if (out_held) begin
                assert (out_valid && out_vertex == held_vertex && out_offset == held_offset &&
                        out_degree == held_degree) else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: output changed while stalled", $time);
                end
            end
            out_held    = out_valid && !out_rd_en;
            held_vertex = out_vertex;
            held_offset = out_offset;
            held_degree = out_degree;
            if (out_valid && out_rd_en) begin
                off = out_vertex - run_first;
                assert (out_vertex >= run_first && off < run_count) else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: vertex %0d outside the range", $time, out_vertex);
                end
                assert (out_offset == out_vertex * 32'd16 + 32'd5 &&
                        out_degree == out_vertex % 32'd4 && out_degree != 32'd0) else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: vertex %0d offset %0d degree %0d", $time,
                             out_vertex, out_offset, out_degree);
                end
                assert (off >= 32'd64 || !seen[off[5:0]]) else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: vertex %0d delivered twice", $time, out_vertex);
                end
                if (off < 32'd64) begin
                    seen[off[5:0]] = 1'b1;
                end
                rec_count++;
            end
            // Done only once every record is out, and nothing after it
            if (done_hold != 0) begin
                done_hold--;
            end else if (done) begin
                assert (!out_valid && rec_count == expected_records(run_first, run_count))
                else begin
                    monitor_errors++;
                    $display("[FAIL] %0t ns: done with %0d records or output pending",
                             $time, rec_count);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Runs
    // ------------------------------------------------------------------------
    task automatic run_range(input int test_id, input logic [31:0] base,
                             input logic [31:0] first, input logic [31:0] count);
        int errs_before;
        int errs;
        logic bit_expected;
        @(negedge ap_clk);
        errs_before = monitor_errors + run_errors;
        @(posedge ap_clk);
        start             <= 1'b1;
        desc_base_addr    <= base;
        desc_first_vertex <= first;
        desc_vertex_count <= count;
        @(posedge ap_clk);
        start <= 1'b0;
        repeat (2) @(posedge ap_clk);
        assert (!done) else begin
            run_errors++;
            $display("[FAIL] %0t ns: done still high after start", $time);
        end
        while (!done) begin
            @(posedge ap_clk);
        end
        @(negedge ap_clk);
        assert (ack_count == int'(count) && rec_count == expected_records(first, count))
        else begin
            run_errors++;
            $display("[FAIL] %0t ns: %0d reads, %0d records", $time, ack_count, rec_count);
        end
        // Bitmap holds exactly the vertices with edges
        for (int i = 0; i < int'(count); i++) begin
            bit_expected = ((first + 32'(i)) % 32'd4) != 32'd0;
            assert (seen[i[5:0]] == bit_expected) else begin
                run_errors++;
                $display("[FAIL] %0t ns: vertex %0d arrival wrong", $time, first + 32'(i));
            end
        end
        // Give the monitor time to see any stray record after done
        repeat (8) @(posedge ap_clk);
        @(negedge ap_clk);
        errs = monitor_errors + run_errors - errs_before;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d: base %h vertices %0d..%0d, %0d records, %0d errors", test_id,
                 base, first, first + count - 32'd1, rec_count, errs);
    endtask

    initial begin
        int total;
        repeat (10) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
        repeat (3) @(posedge ap_clk);
        run_range(0, 32'h1000, 32'd3, 32'd20);
        run_range(1, 32'h8000, 32'd40, 32'd13);
        total = monitor_errors + run_errors;
        $display("tests 2, failed %0d, errors %0d", tests_failed, total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog on the total cycle count
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("timeout: runs did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/csr_engine_pkg.sv */
`default_nettype none

package csr_engine_pkg;

    // -------------------------------------------------------------------------
    // Lane layout
    // -------------------------------------------------------------------------
    // Number of lane units, vertex id low bits pick the lane
    localparam int NUM_LANES = 4;
    localparam int LANE_IDX_W = 2;

    // Records held per lane before it pushes back on the memory strobe
    localparam int LANE_DEPTH = 2;

    // -------------------------------------------------------------------------
    // Bus and record widths
    // -------------------------------------------------------------------------
    // Wishbone byte address
    localparam int ADDR_W = 32;
    // One CSR index word, start offset high, end offset low
    localparam int DATA_W = 64;
    // Vertex id and vertex count
    localparam int VERTEX_W = 32;
    // Edge offsets, degree uses the same width
    localparam int OFFSET_W = 32;

    // Byte distance between consecutive index words
    localparam int INDEX_STRIDE_BYTES = 8;

    // -------------------------------------------------------------------------
    // Generator FSM
    // -------------------------------------------------------------------------
    typedef enum logic [1:0] {
        gen_idle,
        gen_issue,
        gen_wait_ack,
        gen_finish
    } gen_state_t;

endpackage

`default_nettype wire

/* verilog/csr_index_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_index_engine (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic                                  start,
    input  logic [csr_engine_pkg::ADDR_W-1:0]     desc_base_addr,
    input  logic [csr_engine_pkg::VERTEX_W-1:0]   desc_first_vertex,
    input  logic [csr_engine_pkg::VERTEX_W-1:0]   desc_vertex_count,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    output logic [csr_engine_pkg::ADDR_W-1:0]     wb_adr,
    input  logic                                  wb_ack,
    input  logic [csr_engine_pkg::DATA_W-1:0]     wb_dat,
    output logic                                  out_valid,
    input  logic                                  out_rd_en,
    output logic [csr_engine_pkg::VERTEX_W-1:0]   out_vertex,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   out_offset,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   out_degree,
    output logic                                  done
);

    // -------------------------------------------------------------------------
    // Generator side
    // -------------------------------------------------------------------------
    logic                                gen_cyc;
    logic                                gen_stb;
    logic                                gen_ack;
    logic [csr_engine_pkg::ADDR_W-1:0]   gen_adr;
    logic [csr_engine_pkg::VERTEX_W-1:0] gen_vertex;
    logic                                issue_done;

    // Router to lanes, shared write data
    logic [csr_engine_pkg::NUM_LANES-1:0] lane_wr_en;
    logic [csr_engine_pkg::NUM_LANES-1:0] lane_full;
    logic [csr_engine_pkg::VERTEX_W-1:0]  lane_vertex;
    logic [csr_engine_pkg::OFFSET_W-1:0]  lane_start;
    logic [csr_engine_pkg::OFFSET_W-1:0]  lane_end;

    // Lane heads toward the merger
    logic [csr_engine_pkg::NUM_LANES-1:0] rec_valid;
    logic [csr_engine_pkg::NUM_LANES-1:0] rec_pop;
    logic [csr_engine_pkg::VERTEX_W-1:0]  rec_vertex [csr_engine_pkg::NUM_LANES];
    logic [csr_engine_pkg::OFFSET_W-1:0]  rec_offset [csr_engine_pkg::NUM_LANES];
    logic [csr_engine_pkg::OFFSET_W-1:0]  rec_degree [csr_engine_pkg::NUM_LANES];

    csr_index_generator u_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .start             (start),
        .desc_base_addr    (desc_base_addr),
        .desc_first_vertex (desc_first_vertex),
        .desc_vertex_count (desc_vertex_count),
        .gen_ack           (gen_ack),
        .gen_cyc           (gen_cyc),
        .gen_stb           (gen_stb),
        .gen_adr           (gen_adr),
        .gen_vertex        (gen_vertex),
        .issue_done        (issue_done)
    );

    csr_response_router u_router (
        .gen_cyc     (gen_cyc),
        .gen_stb     (gen_stb),
        .gen_adr     (gen_adr),
        .gen_vertex  (gen_vertex),
        .wb_ack      (wb_ack),
        .wb_dat      (wb_dat),
        .lane_full   (lane_full),
        .gen_ack     (gen_ack),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .lane_wr_en  (lane_wr_en),
        .lane_vertex (lane_vertex),
        .lane_start  (lane_start),
        .lane_end    (lane_end)
    );

    // One lane per vertex residue
    for (genvar g = 0; g < csr_engine_pkg::NUM_LANES; g++) begin : g_lane
        csr_index_lane u_lane (
            .ap_clk            (ap_clk),
            .areset_csr_engine (areset_csr_engine),
            .wr_en             (lane_wr_en[g]),
            .wr_vertex         (lane_vertex),
            .wr_start          (lane_start),
            .wr_end            (lane_end),
            .rec_pop           (rec_pop[g]),
            .full              (lane_full[g]),
            .rec_valid         (rec_valid[g]),
            .rec_vertex        (rec_vertex[g]),
            .rec_offset        (rec_offset[g]),
            .rec_degree        (rec_degree[g])
        );
    end

    csr_packet_merger u_merger (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .rec_valid         (rec_valid),
        .rec_vertex        (rec_vertex),
        .rec_offset        (rec_offset),
        .rec_degree        (rec_degree),
        .issue_done        (issue_done),
        .out_rd_en         (out_rd_en),
        .rec_pop           (rec_pop),
        .out_valid         (out_valid),
        .out_vertex        (out_vertex),
        .out_offset        (out_offset),
        .out_degree        (out_degree),
        .done              (done)
    );

endmodule

`default_nettype wire

/* verilog/csr_index_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_index_generator (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic                                  start,
    input  logic [csr_engine_pkg::ADDR_W-1:0]     desc_base_addr,
    input  logic [csr_engine_pkg::VERTEX_W-1:0]   desc_first_vertex,
    input  logic [csr_engine_pkg::VERTEX_W-1:0]   desc_vertex_count,
    input  logic                                  gen_ack,
    output logic                                  gen_cyc,
    output logic                                  gen_stb,
    output logic [csr_engine_pkg::ADDR_W-1:0]     gen_adr,
    output logic [csr_engine_pkg::VERTEX_W-1:0]   gen_vertex,
    output logic                                  issue_done
);

    csr_engine_pkg::gen_state_t state;

    // Descriptor copy and walk position
    logic [csr_engine_pkg::ADDR_W-1:0]   base_addr;
    logic [csr_engine_pkg::VERTEX_W-1:0] vertex;
    logic [csr_engine_pkg::VERTEX_W-1:0] remaining;
    logic [csr_engine_pkg::ADDR_W-1:0]   vertex_offset;

    logic accept;
    logic last_read;
    logic bus_active;

    // Finish behaves as idle for a new descriptor
    assign accept = start &&
                    (state == csr_engine_pkg::gen_idle || state == csr_engine_pkg::gen_finish);
    assign last_read = (remaining == 1);

    // Single read per cycle, strobe tracks cycle
    assign bus_active = (state == csr_engine_pkg::gen_issue) ||
                        (state == csr_engine_pkg::gen_wait_ack);
    assign gen_cyc = bus_active;
    assign gen_stb = bus_active;

    // Word address, stable while waiting since vertex only moves on ack
    assign vertex_offset = vertex * csr_engine_pkg::INDEX_STRIDE_BYTES;
    assign gen_adr = base_addr + vertex_offset;
    assign gen_vertex = vertex;

    assign issue_done = (state == csr_engine_pkg::gen_finish);

    // -------------------------------------------------------------------------
    // State register
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state <= csr_engine_pkg::gen_idle;
        end else begin
            case (state)
                csr_engine_pkg::gen_idle, csr_engine_pkg::gen_finish: begin
                    // Empty range skips straight to finish
                    if (accept) begin
                        state <= (desc_vertex_count == 0) ? csr_engine_pkg::gen_finish
                                                          : csr_engine_pkg::gen_issue;
                    end
                end
                csr_engine_pkg::gen_issue, csr_engine_pkg::gen_wait_ack: begin
                    if (gen_ack) begin
                        state <= last_read ? csr_engine_pkg::gen_finish
                                           : csr_engine_pkg::gen_issue;
                    end else begin
                        state <= csr_engine_pkg::gen_wait_ack;
                    end
                end
                default: state <= csr_engine_pkg::gen_idle;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Walk position
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            base_addr <= desc_base_addr;
            vertex    <= desc_first_vertex;
            remaining <= desc_vertex_count;
        end else if (bus_active && gen_ack) begin
            // Next vertex in ascending order
            vertex    <= vertex + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/csr_index_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_index_lane (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic                                  wr_en,
    input  logic [csr_engine_pkg::VERTEX_W-1:0]   wr_vertex,
    input  logic [csr_engine_pkg::OFFSET_W-1:0]   wr_start,
    input  logic [csr_engine_pkg::OFFSET_W-1:0]   wr_end,
    input  logic                                  rec_pop,
    output logic                                  full,
    output logic                                  rec_valid,
    output logic [csr_engine_pkg::VERTEX_W-1:0]   rec_vertex,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   rec_offset,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   rec_degree
);

    // Record storage
    logic [csr_engine_pkg::VERTEX_W-1:0] buf_vertex [csr_engine_pkg::LANE_DEPTH];
    logic [csr_engine_pkg::OFFSET_W-1:0] buf_offset [csr_engine_pkg::LANE_DEPTH];
    logic [csr_engine_pkg::OFFSET_W-1:0] buf_degree [csr_engine_pkg::LANE_DEPTH];

    logic [$clog2(csr_engine_pkg::LANE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(csr_engine_pkg::LANE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(csr_engine_pkg::LANE_DEPTH+1)-1:0] count;

    logic [csr_engine_pkg::OFFSET_W-1:0] wr_degree;
    logic push;
    logic pop;

    // Degree of the incoming vertex
    assign wr_degree = wr_end - wr_start;

    // Vertices without edges never take a slot
    assign push = wr_en && (wr_degree != 0);
    assign pop  = rec_pop && rec_valid;

    assign full      = (count == csr_engine_pkg::LANE_DEPTH);
    assign rec_valid = (count != 0);

    // Head of the buffer
    assign rec_vertex = buf_vertex[rd_ptr];
    assign rec_offset = buf_offset[rd_ptr];
    assign rec_degree = buf_degree[rd_ptr];

    // -------------------------------------------------------------------------
    // Pointers and occupancy
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == csr_engine_pkg::LANE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == csr_engine_pkg::LANE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            buf_vertex[wr_ptr] <= wr_vertex;
            buf_offset[wr_ptr] <= wr_start;
            buf_degree[wr_ptr] <= wr_degree;
        end
    end

endmodule

`default_nettype wire

/* verilog/csr_packet_merger.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_packet_merger (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic [csr_engine_pkg::NUM_LANES-1:0]  rec_valid,
    input  logic [csr_engine_pkg::VERTEX_W-1:0]   rec_vertex [csr_engine_pkg::NUM_LANES],
    input  logic [csr_engine_pkg::OFFSET_W-1:0]   rec_offset [csr_engine_pkg::NUM_LANES],
    input  logic [csr_engine_pkg::OFFSET_W-1:0]   rec_degree [csr_engine_pkg::NUM_LANES],
    input  logic                                  issue_done,
    input  logic                                  out_rd_en,
    output logic [csr_engine_pkg::NUM_LANES-1:0]  rec_pop,
    output logic                                  out_valid,
    output logic [csr_engine_pkg::VERTEX_W-1:0]   out_vertex,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   out_offset,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   out_degree,
    output logic                                  done
);

    // Last lane served, search starts just after it
    logic [csr_engine_pkg::LANE_IDX_W-1:0] last_lane;
    logic [csr_engine_pkg::LANE_IDX_W-1:0] pick;
    logic pick_valid;
    logic load;

    // -------------------------------------------------------------------------
    // Round-robin pick
    // -------------------------------------------------------------------------
    always_comb begin
        logic [csr_engine_pkg::LANE_IDX_W-1:0] idx;
        pick       = last_lane;
        pick_valid = 1'b0;
        // Walk from farthest to nearest so the nearest valid lane wins
        for (int i = csr_engine_pkg::NUM_LANES; i >= 1; i--) begin
            idx = last_lane + i[csr_engine_pkg::LANE_IDX_W-1:0];
            if (rec_valid[idx]) begin
                pick       = idx;
                pick_valid = 1'b1;
            end
        end
    end

    // Refill when empty or drained this cycle
    assign load = pick_valid && (!out_valid || out_rd_en);

    always_comb begin
        rec_pop = '0;
        if (load) begin
            rec_pop[pick] = 1'b1;
        end
    end

    // -------------------------------------------------------------------------
    // Output register and done flag
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            out_valid <= 1'b0;
            last_lane <= '0;
            done      <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
                last_lane <= pick;
            end else if (out_rd_en) begin
                out_valid <= 1'b0;
            end
            // Whole range issued and nothing left anywhere
            done <= issue_done && (rec_valid == '0) && !out_valid;
        end
    end

    // Payload holds under back-pressure
    always_ff @(posedge ap_clk) begin
        if (load) begin
            out_vertex <= rec_vertex[pick];
            out_offset <= rec_offset[pick];
            out_degree <= rec_degree[pick];
        end
    end

endmodule

`default_nettype wire

/* verilog/csr_response_router.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_response_router (
    input  logic                                  gen_cyc,
    input  logic                                  gen_stb,
    input  logic [csr_engine_pkg::ADDR_W-1:0]     gen_adr,
    input  logic [csr_engine_pkg::VERTEX_W-1:0]   gen_vertex,
    input  logic                                  wb_ack,
    input  logic [csr_engine_pkg::DATA_W-1:0]     wb_dat,
    input  logic [csr_engine_pkg::NUM_LANES-1:0]  lane_full,
    output logic                                  gen_ack,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    output logic [csr_engine_pkg::ADDR_W-1:0]     wb_adr,
    output logic [csr_engine_pkg::NUM_LANES-1:0]  lane_wr_en,
    output logic [csr_engine_pkg::VERTEX_W-1:0]   lane_vertex,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   lane_start,
    output logic [csr_engine_pkg::OFFSET_W-1:0]   lane_end
);

    // Lane chosen by vertex modulo lane count
    logic [csr_engine_pkg::LANE_IDX_W-1:0] target_lane;

    assign target_lane = gen_vertex[csr_engine_pkg::LANE_IDX_W-1:0];

    // Cycle and address pass through, strobe waits for room in the lane
    assign wb_cyc = gen_cyc;
    assign wb_stb = gen_stb && !lane_full[target_lane];
    assign wb_adr = gen_adr;
    assign gen_ack = wb_ack;

    // Index word split, start offset in upper half
    assign lane_vertex = gen_vertex;
    assign lane_start  = wb_dat[csr_engine_pkg::DATA_W-1 -: csr_engine_pkg::OFFSET_W];
    assign lane_end    = wb_dat[csr_engine_pkg::OFFSET_W-1:0];

    // Write lands in the lane during the ack cycle itself
    always_comb begin
        lane_wr_en = '0;
        if (gen_cyc && wb_stb && wb_ack) begin
            lane_wr_en[target_lane] = 1'b1;
        end
    end

endmodule

`default_nettype wire
